/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lock_tb
FILELIST = all.f
OBJ      = obj_dir
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ)

/* all.f */
src/lock_pkg.sv
src/code_store.sv
src/code_matcher.sv
src/door_fsm.sv
src/lock_top.sv
verification/lock_tb.sv

/* src/code_matcher.sv */
`timescale 1ns/10ps
`default_nettype none

module code_matcher import lock_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  check_start,
    input  code_t check_code,
    output slot_t rd_slot,
    input  code_t rd_code,
    output logic  check_done,
    output logic  check_ok
);

    slot_t slot_q;     // Slot under compare, back at 0 when idle
    logic  busy;
    logic  match_q;
    logic  hit;

    // Unset slots never match, even against an all-F entry
    assign hit = (rd_code == check_code) && (rd_code != CODE_UNSET);

    assign rd_slot = slot_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_q     <= '0;
            busy       <= 1'b0;
            match_q    <= 1'b0;
            check_done <= 1'b0;
            check_ok   <= 1'b0;
        end else begin
            check_done <= 1'b0;
            if (check_start) begin
                // Slot 0 is compared in the start cycle
                busy    <= 1'b1;
                match_q <= hit;
                slot_q  <= slot_q + 2'd1;
            end else if (busy) begin
                match_q <= match_q || hit;
                slot_q  <= slot_q + 2'd1;  // Wraps to 0 after slot 3
                if (slot_q == slot_t'(CODE_SLOTS - 1)) begin
                    busy       <= 1'b0;
                    check_done <= 1'b1;
                    check_ok   <= match_q || hit;
                end
            end
        end
    end

    // One check at a time
    a_no_overlap: assert property (
        @(posedge clk) disable iff (rst)
        check_start |-> !busy
    );

    // Verdict four cycles after the start pulse
    a_done_latency: assert property (
        @(posedge clk) disable iff (rst)
        check_start |-> ##4 check_done
    );

endmodule

`default_nettype wire

/* src/code_store.sv */
`timescale 1ns/10ps
`default_nettype none

module code_store import lock_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    // APB slave
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  slot_t paddr,
    input  code_t pwdata,
    output code_t prdata,
    output logic  pready,
    // Matcher read port
    input  slot_t rd_slot,
    output code_t rd_code
);

    code_t code_mem [CODE_SLOTS];
    logic  apb_write;

    // Access phase of a write, no wait states
    assign apb_write = psel && penable && pwrite;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < CODE_SLOTS; i++) begin
                code_mem[i] <= (i == 0) ? DEFAULT_CODE0 : CODE_UNSET;
            end
        end else if (apb_write) begin
            code_mem[paddr] <= pwdata;  // Visible to the next check
        end
    end

    // Read data is valid during the access cycle
    assign prdata = code_mem[paddr];
    assign pready = 1'b1;

    // Same-cycle read for the matcher
    assign rd_code = code_mem[rd_slot];

    // Access phase always follows a setup phase
    a_penable_psel: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel
    );

endmodule

`default_nettype wire

/* src/door_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module door_fsm import lock_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 100,
    parameter int RELOCK_CYCLES   = 5000,
    parameter int BIP_CYCLES      = 5000,
    parameter int RETRY_CYCLES    = 1000,
    parameter int LOCKOUT_CYCLES  = 30000,
    parameter int MAX_ATTEMPTS    = 5
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      door_open,
    input  logic      inner_button,
    input  logic      code_valid,
    input  code_t     code,
    output logic      check_start,
    output code_t     check_code,
    input  logic      check_done,
    input  logic      check_ok,
    output logic      lock,
    output logic      bip,
    output logic      keypad_en,
    output status_t   status,
    output attempts_t fail_count
);

    // Shared counter sized for the longest interval
    localparam int MAX_A   = (DEBOUNCE_CYCLES > RELOCK_CYCLES) ? DEBOUNCE_CYCLES : RELOCK_CYCLES;
    localparam int MAX_B   = (BIP_CYCLES > RETRY_CYCLES) ? BIP_CYCLES : RETRY_CYCLES;
    localparam int MAX_AB  = (MAX_A > MAX_B) ? MAX_A : MAX_B;
    localparam int CNT_MAX = (MAX_AB > LOCKOUT_CYCLES) ? MAX_AB : LOCKOUT_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t DB_LAST      = cnt_t'(DEBOUNCE_CYCLES - 1);
    localparam cnt_t RELOCK_LAST  = cnt_t'(RELOCK_CYCLES - 1);
    localparam cnt_t BIP_LAST     = cnt_t'(BIP_CYCLES - 1);
    localparam cnt_t RETRY_LAST   = cnt_t'(RETRY_CYCLES - 1);
    localparam cnt_t LOCKOUT_LAST = cnt_t'(LOCKOUT_CYCLES - 1);

    localparam attempts_t ATT_LIMIT = attempts_t'(MAX_ATTEMPTS);
    localparam attempts_t ATT_SAT   = '1;

    typedef enum logic [3:0] {
        INIT,
        LOCKED,
        CHECK,      // Waiting for the matcher
        AJAR,       // Bolt retracted, door closed
        OPEN,
        BIP_OPEN,   // Open too long
        DB_UNLOCK,  // Button held while locked
        DB_LOCK,    // Button held while ajar
        BLOCKED     // Retry wait or lockout
    } state_t;

    state_t    state;
    cnt_t      cnt;
    cnt_t      hold_last;
    code_t     code_q;
    attempts_t fails;
    digit_t    first_digit;
    logic      take_code;

    assign first_digit = code[15:12];

    // Button has priority over the keypad
    assign take_code = (state == LOCKED) && !inner_button && code_valid &&
                       (first_digit != DIGIT_BLANK) && (first_digit != DIGIT_EMPTY);

    // Long lockout once the limit is exceeded
    assign hold_last = (fails > ATT_LIMIT) ? LOCKOUT_LAST : RETRY_LAST;

    assign check_code = code_q;
    assign fail_count = fails;

    always_ff @(posedge clk) begin
        if (take_code) begin
            code_q <= code;  // Held until check_done
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= INIT;
            cnt         <= '0;
            fails       <= '0;
            check_start <= 1'b0;
        end else begin
            check_start <= take_code;
            case (state)
                INIT: begin
                    if (!door_open) state <= LOCKED;
                end

                LOCKED: begin
                    cnt <= '0;
                    if (inner_button) begin
                        state <= DB_UNLOCK;
                    end else if (take_code) begin
                        state <= CHECK;
                    end
                end

                CHECK: begin
                    cnt <= '0;
                    if (check_done) begin
                        if (check_ok) begin
                            state <= AJAR;
                            fails <= '0;
                        end else begin
                            state <= BLOCKED;
                            if (fails != ATT_SAT) fails <= fails + 3'd1;
                        end
                    end
                end

                BLOCKED: begin
                    if (cnt >= hold_last) begin
                        state <= LOCKED;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                AJAR: begin
                    if (door_open) begin
                        state <= OPEN;
                        cnt   <= '0;
                    end else if (inner_button) begin
                        state <= DB_LOCK;
                        cnt   <= '0;
                    end else if (cnt >= RELOCK_LAST) begin
                        state <= LOCKED;  // Auto relock
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                OPEN: begin
                    if (!door_open) begin
                        state <= AJAR;
                        cnt   <= '0;
                    end else if (cnt >= BIP_LAST) begin
                        state <= BIP_OPEN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                BIP_OPEN: begin
                    if (!door_open) begin
                        state <= AJAR;
                        cnt   <= '0;
                    end
                end

                // Both debounce states act on the falling edge of the button
                DB_UNLOCK: begin
                    if (!inner_button) begin
                        cnt <= '0;
                        if (cnt >= DB_LAST) begin
                            state <= AJAR;
                            fails <= '0;
                        end else begin
                            state <= LOCKED;  // Too short
                        end
                    end else if (cnt < DB_LAST) begin
                        cnt <= cnt + 1'b1;
                    end
                end

                DB_LOCK: begin
                    if (!inner_button) begin
                        cnt   <= '0;
                        state <= (cnt >= DB_LAST) ? LOCKED : AJAR;
                    end else if (cnt < DB_LAST) begin
                        cnt <= cnt + 1'b1;
                    end
                end

                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

    // Outputs decoded from state only
    always_comb begin
        lock      = 1'b0;
        bip       = 1'b0;
        keypad_en = 1'b0;
        status    = ST_INIT;
        case (state)
            INIT: status = ST_INIT;
            LOCKED: begin
                lock      = 1'b1;
                keypad_en = 1'b1;
                status    = ST_LOCKED;
            end
            CHECK: begin
                lock   = 1'b1;
                status = ST_BUSY;
            end
            BLOCKED: begin
                lock   = 1'b1;
                status = ST_BLOCKED;
            end
            AJAR: status = ST_AJAR;
            OPEN: status = ST_OPEN;
            BIP_OPEN: begin
                bip    = 1'b1;
                status = ST_OPEN;
            end
            DB_UNLOCK: begin
                lock   = 1'b1;
                status = ST_BUSY;
            end
            DB_LOCK: status = ST_BUSY;
            default: status = ST_INIT;
        endcase
    end

    a_lock_bip: assert property (
        @(posedge clk) disable iff (rst)
        !(lock && bip)
    );

    // Matcher answers only the check this FSM is waiting on
    a_done_in_check: assert property (
        @(posedge clk) disable iff (rst)
        check_done |-> state == CHECK
    );

endmodule

`default_nettype wire

/* src/lock_pkg.sv */
`default_nettype none

package lock_pkg;

    // Keypad digit, BCD 0-9 plus special codes
    typedef logic [3:0]  digit_t;

    // Four digits, digit 0 (first key) in the top nibble
    typedef logic [15:0] code_t;

    typedef logic [1:0]  slot_t;      // Stored code slot 0..3
    typedef logic [2:0]  attempts_t;  // Failed attempt count

    // Status digit shown on the display
    typedef enum logic [3:0] {
        ST_INIT    = 4'h0,
        ST_LOCKED  = 4'h1,
        ST_AJAR    = 4'h2,
        ST_OPEN    = 4'h3,
        ST_BLOCKED = 4'hA,
        ST_BUSY    = 4'hB
    } status_t;

    localparam int CODE_SLOTS = 4;

    localparam digit_t DIGIT_BLANK = 4'hB;  // "#" key or blank
    localparam digit_t DIGIT_EMPTY = 4'hF;

    // Unset slot, never matches
    localparam code_t CODE_UNSET = {4{DIGIT_EMPTY}};

    // Slot 0 after reset, keys 1,2,3,4
    localparam code_t DEFAULT_CODE0 = 16'h1234;

endpackage

`default_nettype wire

/* src/lock_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lock_top import lock_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 100,
    parameter int RELOCK_CYCLES   = 5000,
    parameter int BIP_CYCLES      = 5000,
    parameter int RETRY_CYCLES    = 1000,
    parameter int LOCKOUT_CYCLES  = 30000,
    parameter int MAX_ATTEMPTS    = 5
) (
    input  logic      clk,
    input  logic      rst,
    // Keypad
    input  logic      code_valid,
    input  code_t     code,
    // Sensors and button
    input  logic      door_open,
    input  logic      inner_button,
    // APB access to the code slots
    input  slot_t     paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  code_t     pwdata,
    output code_t     prdata,
    output logic      pready,
    // Lock outputs
    output logic      lock,
    output logic      bip,
    output logic      keypad_en,
    output status_t   status,
    output attempts_t fail_count
);

    logic  check_start;
    logic  check_done;
    logic  check_ok;
    code_t check_code;
    slot_t rd_slot;
    code_t rd_code;

    code_store u_store (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .rd_slot (rd_slot),
        .rd_code (rd_code)
    );

    code_matcher u_matcher (
        .clk         (clk),
        .rst         (rst),
        .check_start (check_start),
        .check_code  (check_code),
        .rd_slot     (rd_slot),
        .rd_code     (rd_code),
        .check_done  (check_done),
        .check_ok    (check_ok)
    );

    door_fsm #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .RELOCK_CYCLES   (RELOCK_CYCLES),
        .BIP_CYCLES      (BIP_CYCLES),
        .RETRY_CYCLES    (RETRY_CYCLES),
        .LOCKOUT_CYCLES  (LOCKOUT_CYCLES),
        .MAX_ATTEMPTS    (MAX_ATTEMPTS)
    ) u_fsm (
        .clk          (clk),
        .rst          (rst),
        .door_open    (door_open),
        .inner_button (inner_button),
        .code_valid   (code_valid),
        .code         (code),
        .check_start  (check_start),
        .check_code   (check_code),
        .check_done   (check_done),
        .check_ok     (check_ok),
        .lock         (lock),
        .bip          (bip),
        .keypad_en    (keypad_en),
        .status       (status),
        .fail_count   (fail_count)
    );

endmodule

`default_nettype wire

/* verification/lock_stim.txt */
// Record op_sel_data_limit in hex. Op 1 APB write, 2 APB read (sel slot, data code)
// Op 3 key (data code), 4 levels (data digits door, button), 5 wait (limit cycles)
// Op 6 expect (sel status, data digits lock bip keypad_en fail_count, limit max cycles)
6_0_0000_0000  // INIT right after reset
6_1_1010_0004
3_0_1234_0000  // Default code
6_2_0000_000A
5_0_0000_0010
6_2_0000_0000  // Still ajar before the relock time
6_1_1010_0010
3_0_9999_0000
6_A_1001_000A
6_1_1011_0010  // Retry wait over
3_0_9999_0000
6_A_1002_000A
6_1_1012_0010
3_0_9999_0000  // Third failure, beyond the limit
6_A_1003_000A
5_0_0000_0014
6_A_1003_0000  // Held past the retry wait
6_1_1013_0020
3_0_1234_0000
6_2_0000_000A  // Success clears the count
6_1_1010_0020
1_2_5678_0000
2_2_5678_0000
2_0_1234_0000
2_1_FFFF_0000
3_0_5678_0000
6_2_0000_000A
6_1_1010_0020
1_0_FFFF_0000  // Clear slot 0
2_0_FFFF_0000
3_0_1234_0000
6_A_1001_000A
6_1_1011_0010
3_0_FFFF_0000  // Empty first digit, ignored
5_0_0000_0008
6_1_1011_0000
4_0_0100_0000  // Short press
6_B_1001_0000
5_0_0000_0001
4_0_0000_0000
6_1_1011_0002
4_0_0100_0000  // Long press unlocks
5_0_0000_0006
4_0_0000_0000
6_2_0000_0002
4_0_0100_0000  // Same press relocks
6_B_0000_0000
5_0_0000_0006
4_0_0000_0000
6_1_1010_0002
3_0_5678_0000
6_2_0000_000A
4_0_1000_0000  // Door opens
6_3_0000_0002
5_0_0000_000C
6_3_0000_0000
6_3_0100_0010  // Bip after the open time
4_0_0000_0000
6_2_0000_0002
6_1_1010_0020
0_0_0000_0000

/* verification/lock_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module lock_tb;

    // Short intervals so every path finishes quickly
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int RELOCK_CYCLES   = 20;
    localparam int BIP_CYCLES      = 16;
    localparam int RETRY_CYCLES    = 8;
    localparam int LOCKOUT_CYCLES  = 40;
    localparam int MAX_ATTEMPTS    = 2;

    localparam int STIM_DEPTH    = 128;
    localparam int RESET_CYCLES  = 10;
    localparam int MARGIN_CYCLES = 50;

    logic        clk;
    logic        rst;
    logic        code_valid;
    logic [15:0] code;
    logic        door_open;
    logic        inner_button;
    logic [1:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;
    logic        lock;
    logic        bip;
    logic        keypad_en;
    logic [3:0]  status;
    logic [2:0]  fail_count;

    logic [39:0] stim_mem [STIM_DEPTH];  // Op, sel, data, limit as hex digits
    int          err_count;
    int          budget_cycles;
    logic        budget_ready;

    lock_top #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .RELOCK_CYCLES   (RELOCK_CYCLES),
        .BIP_CYCLES      (BIP_CYCLES),
        .RETRY_CYCLES    (RETRY_CYCLES),
        .LOCKOUT_CYCLES  (LOCKOUT_CYCLES),
        .MAX_ATTEMPTS    (MAX_ATTEMPTS)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .code_valid   (code_valid),
        .code         (code),
        .door_open    (door_open),
        .inner_button (inner_button),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .lock         (lock),
        .bip          (bip),
        .keypad_en    (keypad_en),
        .status       (status),
        .fail_count   (fail_count)
    );

    always #20 clk = ~clk;  // 40 ns period

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            err_count++;
            $display("ERR %0t ns %s: got %0h, expected %0h", $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Run aborted");
    endtask

    // Setup phase, then access phase with read data checked mid-cycle
    task automatic apb_transfer(input logic write, input logic [1:0] slot,
                                input logic [15:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = slot;
        pwdata  = write ? data : 16'h0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #10;
        check_value("pready", 32'(pready), 32'h1);
        if (!write) begin
            check_value("prdata", 32'(prdata), 32'(data));
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic press_key(input logic [15:0] key_code);
        code       = key_code;
        code_valid = 1'b1;  // One-cycle pulse
        @(posedge clk);
        #2;
        code_valid = 1'b0;
    endtask

    task automatic set_levels(input logic door, input logic button);
        door_open    = door;
        inner_button = button;
        @(posedge clk);
        #2;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Flags digits: lock, bip, keypad_en, fail_count
    function automatic logic outputs_match(input logic [3:0] st, input logic [15:0] flags);
        return (status === st) && (lock === flags[12]) && (bip === flags[8]) &&
               (keypad_en === flags[4]) && (fail_count === flags[2:0]);
    endfunction

    task automatic expect_outputs(input logic [3:0] st, input logic [15:0] flags,
                                  input int limit);
        int   waited;
        logic match;
        waited = 0;
        match  = outputs_match(st, flags);
        while (!match && waited < limit) begin
            @(posedge clk);
            #2;
            waited++;
            match = outputs_match(st, flags);
        end
        check_value("status", 32'(status), 32'(st));
        check_value("lock", 32'(lock), 32'(flags[12]));
        check_value("bip", 32'(bip), 32'(flags[8]));
        check_value("keypad_en", 32'(keypad_en), 32'(flags[4]));
        check_value("fail_count", 32'(fail_count), 32'(flags[2:0]));
    endtask

    initial begin
        int          idx;
        logic [3:0]  op;
        logic [3:0]  sel;
        logic [15:0] data;
        logic [15:0] limit;
        clk           = 1'b0;
        rst           = 1'b1;
        code_valid    = 1'b0;
        code          = 16'h0;
        door_open     = 1'b0;   // Door closed from the start
        inner_button  = 1'b0;
        paddr         = 2'd0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = 16'h0;
        err_count     = 0;
        budget_cycles = 0;
        budget_ready  = 1'b0;

        for (idx = 0; idx < STIM_DEPTH; idx++) begin
            stim_mem[idx] = '0;
        end
        $readmemh("verification/lock_stim.txt", stim_mem);
        if (stim_mem[0][39:36] == 4'h0) begin
            abort_run("Stimulus file is empty or could not be read");
        end

        // Watchdog budget from the waits and bounded expects in the file
        budget_cycles = RESET_CYCLES + MARGIN_CYCLES;
        idx = 0;
        while (idx < STIM_DEPTH && stim_mem[idx][39:36] != 4'h0) begin
            case (stim_mem[idx][39:36])
                4'h1, 4'h2: budget_cycles += 2;
                4'h5, 4'h6: budget_cycles += int'(stim_mem[idx][15:0]);
                default:    budget_cycles += 1;
            endcase
            idx++;
        end
        budget_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        idx = 0;
        while (idx < STIM_DEPTH && stim_mem[idx][39:36] != 4'h0) begin
            op    = stim_mem[idx][39:36];
            sel   = stim_mem[idx][35:32];
            data  = stim_mem[idx][31:16];
            limit = stim_mem[idx][15:0];
            case (op)
                4'h1: apb_transfer(1'b1, sel[1:0], data);
                4'h2: apb_transfer(1'b0, sel[1:0], data);
                4'h3: press_key(data);
                4'h4: set_levels(data[12], data[8]);
                4'h5: wait_cycles(int'(limit));
                4'h6: expect_outputs(sel, data, int'(limit));
                default: abort_run($sformatf("Unknown stimulus op %0h in record %0d", op, idx));
            endcase
            idx++;
        end

        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (budget_ready);
        repeat (budget_cycles) @(posedge clk);
        abort_run($sformatf("Timeout: stimulus still running after %0d cycles", budget_cycles));
    end

endmodule

`default_nettype wire
